/* source/isa_pkg.sv */
package isa_pkg;

    // data word width of the integer core
    localparam int xlen = 32;

    // instruction field widths
    localparam int opcode_w  = 7;
    localparam int funct3_w  = 3;
    localparam int reg_idx_w = 5;

    // major opcodes handled by the back end
    localparam logic [opcode_w-1:0] opc_load   = 7'b0000011;
    localparam logic [opcode_w-1:0] opc_store  = 7'b0100011;
    localparam logic [opcode_w-1:0] opc_op_imm = 7'b0010011;
    localparam logic [opcode_w-1:0] opc_jal    = 7'b1101111;

    // funct3 codes for memory access size
    // store codes share the load encoding for b, h and w
    localparam logic [funct3_w-1:0] f3_b  = 3'b000;
    localparam logic [funct3_w-1:0] f3_h  = 3'b001;
    localparam logic [funct3_w-1:0] f3_w  = 3'b010;
    localparam logic [funct3_w-1:0] f3_bu = 3'b100;
    localparam logic [funct3_w-1:0] f3_hu = 3'b101;

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // i-type layout, used by loads, op-imm and for the jal rd field
    typedef struct packed {
        logic [11:0]         imm;
        reg_idx_t            rs1;
        logic [funct3_w-1:0] funct3;
        reg_idx_t            rd;
        logic [opcode_w-1:0] opcode;
    } i_type_t;

    // s-type layout, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0]          imm_hi;
        reg_idx_t            rs2;
        reg_idx_t            rs1;
        logic [funct3_w-1:0] funct3;
        logic [4:0]          imm_lo;
        logic [opcode_w-1:0] opcode;
    } s_type_t;

    // one instruction word seen through either format
    typedef union packed {
        logic [xlen-1:0] raw;
        i_type_t         i;
        s_type_t         s;
    } instr_u;

endpackage

/* source/pipe_pkg.sv */
package pipe_pkg;

    // width of one byte lane in the data word
    localparam int lane_w = 8;

    // byte offset inside a 32-bit word
    localparam int offset_w = 2;

    // source of the register write value
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_pc4 = 2'd1,
        wb_mem = 2'd2
    } wb_sel_t;

    // access size and signedness, funct3 carried down the pipe
    typedef logic [2:0] mem_size_t;

endpackage

/* source/exmem_if.sv */
`timescale 1ns/1ps

interface exmem_if;
    import isa_pkg::*;
    import pipe_pkg::*;

    logic            valid;
    // effective address for memory ops, sum for addi
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] pc4;
    // raw rs2, lane alignment happens in the memory stage
    logic [xlen-1:0] store_data;
    mem_size_t       funct3;
    logic            mem_wr_en;
    logic            reg_wr_en;
    wb_sel_t         wb_sel;
    reg_idx_t        rd;

    modport src (
        output valid, alu_out, pc4, store_data, funct3,
        output mem_wr_en, reg_wr_en, wb_sel, rd
    );

    modport dst (
        input valid, alu_out, pc4, store_data, funct3,
        input mem_wr_en, reg_wr_en, wb_sel, rd
    );

endinterface

/* source/memwb_if.sv */
`timescale 1ns/1ps

interface memwb_if;
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                valid;
    logic [xlen-1:0]     alu_out;
    logic [xlen-1:0]     pc4;
    mem_size_t           funct3;
    // low address bits, needed to pick the loaded lanes
    logic [offset_w-1:0] byte_offset;
    logic                reg_wr_en;
    wb_sel_t             wb_sel;
    reg_idx_t            rd;
    // whole addressed word straight from the ram output register
    logic [xlen-1:0]     mem_rd_data;

    modport src (
        output valid, alu_out, pc4, funct3, byte_offset,
        output reg_wr_en, wb_sel, rd, mem_rd_data
    );

    modport dst (
        input valid, alu_out, pc4, funct3, byte_offset,
        input reg_wr_en, wb_sel, rd, mem_rd_data
    );

endinterface

/* source/data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
    parameter int mem_words = 256
) (
    input  logic                         clk,
    input  logic [$clog2(mem_words)-1:0] word_addr,
    input  logic [3:0]                   byte_wr_en,
    input  logic [31:0]                  data_in,
    output logic [31:0]                  data_out
);
    import pipe_pkg::*;

    // contents come up undefined, software initializes what it reads
    logic [31:0] ram [mem_words];

    // byte lane writes, one per set enable
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (byte_wr_en[lane]) begin
                ram[word_addr][lane*lane_w +: lane_w] <= data_in[lane*lane_w +: lane_w];
            end
        end
    end

    // read every cycle
    // same-word write in this cycle is not visible until the next read
    always_ff @(posedge clk) begin
        data_out <= ram[word_addr];
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  isa_pkg::instr_u instr,
    input  logic [31:0]     pc,
    input  logic [31:0]     rs1_data,
    input  logic [31:0]     rs2_data,
    exmem_if.src            ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [opcode_w-1:0] opcode;
    logic [xlen-1:0]     imm;
    logic                is_load;
    logic                is_store;
    logic                is_addi;
    logic                is_jal;
    logic                writes_rd;
    wb_sel_t             wb_sel;

    // opcode sits in the same place in every format
    assign opcode = instr.raw[opcode_w-1:0];

    assign is_load  = (opcode == opc_load);
    assign is_store = (opcode == opc_store);
    // only funct3 zero of op-imm is supported, that is addi
    assign is_addi  = (opcode == opc_op_imm) && (instr.i.funct3 == '0);
    assign is_jal   = (opcode == opc_jal);

    // immediate comes from the s fields for stores, i field otherwise
    always_comb begin
        if (is_store) begin
            imm = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
        end else begin
            imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
        end
    end

    // write value source by instruction kind
    always_comb begin
        if (is_load) begin
            wb_sel = wb_mem;
        end else if (is_jal) begin
            wb_sel = wb_pc4;
        end else begin
            wb_sel = wb_alu;
        end
    end

    // stores keep imm[4:0] in the rd slot, so they never count as a write
    // x0 writes are dropped here as well
    assign writes_rd = (is_load || is_addi || is_jal) && (instr.i.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid      <= 1'b0;
            ex.alu_out    <= '0;
            ex.pc4        <= '0;
            ex.store_data <= '0;
            ex.funct3     <= '0;
            ex.mem_wr_en  <= 1'b0;
            ex.reg_wr_en  <= 1'b0;
            ex.wb_sel     <= wb_alu;
            ex.rd         <= '0;
        end else begin
            ex.valid      <= in_valid;
            // one adder serves both address and addi
            ex.alu_out    <= rs1_data + imm;
            // link value for jal
            ex.pc4        <= pc + 32'd4;
            ex.store_data <= rs2_data;
            ex.funct3     <= instr.i.funct3;
            ex.mem_wr_en  <= is_store;
            ex.reg_wr_en  <= writes_rd;
            ex.wb_sel     <= wb_sel;
            ex.rd         <= instr.i.rd;
        end
    end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage #(
    parameter int mem_words = 256
) (
    input logic  clk,
    input logic  reset,
    exmem_if.dst ex,
    memwb_if.src wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int addr_w = $clog2(mem_words);

    logic [addr_w-1:0]   word_addr;
    logic [offset_w-1:0] byte_offset;
    logic                store_en;
    logic [3:0]          byte_wr_en;
    logic [xlen-1:0]     mem_data_in;

    // word index above the byte offset bits, upper address bits dropped
    assign word_addr   = ex.alu_out[addr_w+offset_w-1:offset_w];
    assign byte_offset = ex.alu_out[offset_w-1:0];

    // a bubble may carry a stale store decode, so gate by valid
    assign store_en = ex.valid && ex.mem_wr_en;

    // move store data into its lanes and build the byte enables
    always_comb begin
        byte_wr_en  = 4'b0000;
        mem_data_in = ex.store_data;
        if (store_en) begin
            case (ex.funct3)
                f3_w: begin
                    byte_wr_en = 4'b1111;
                end
                f3_h: begin
                    // halfword placement uses offset bit 1 only
                    byte_wr_en  = byte_offset[1] ? 4'b1100 : 4'b0011;
                    mem_data_in = ex.store_data << (2 * lane_w * byte_offset[1]);
                end
                f3_b: begin
                    byte_wr_en  = 4'b0001 << byte_offset;
                    mem_data_in = ex.store_data << (lane_w * byte_offset);
                end
                default: begin
                    // undefined store size writes nothing
                    byte_wr_en = 4'b0000;
                end
            endcase
        end
    end

    // read data is registered inside the ram, in step with the payload below
    data_memory #(
        .mem_words (mem_words)
    ) u_data_memory (
        .clk        (clk),
        .word_addr  (word_addr),
        .byte_wr_en (byte_wr_en),
        .data_in    (mem_data_in),
        .data_out   (wb.mem_rd_data)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid       <= 1'b0;
            wb.alu_out     <= '0;
            wb.pc4         <= '0;
            wb.funct3      <= '0;
            wb.byte_offset <= '0;
            wb.reg_wr_en   <= 1'b0;
            wb.wb_sel      <= wb_alu;
            wb.rd          <= '0;
        end else begin
            wb.valid       <= ex.valid;
            wb.alu_out     <= ex.alu_out;
            wb.pc4         <= ex.pc4;
            wb.funct3      <= ex.funct3;
            wb.byte_offset <= byte_offset;
            wb.reg_wr_en   <= ex.reg_wr_en;
            wb.wb_sel      <= ex.wb_sel;
            wb.rd          <= ex.rd;
        end
    end

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic              clk,
    input  logic              reset,
    memwb_if.dst              wb,
    output logic              reg_wr_en,
    output isa_pkg::reg_idx_t reg_wr_rd,
    output logic [31:0]       reg_wr_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [offset_w-1:0] lane_sel;
    logic [xlen-1:0]     lane_data;
    logic [xlen-1:0]     load_value;
    logic [xlen-1:0]     wr_value;

    // lane shift per access size
    // halfwords follow offset bit 1, words are never shifted
    always_comb begin
        case (wb.funct3)
            f3_h, f3_hu: lane_sel = {wb.byte_offset[1], 1'b0};
            f3_w:        lane_sel = '0;
            default:     lane_sel = wb.byte_offset;
        endcase
    end

    // addressed byte or half lands in the low lanes
    assign lane_data = wb.mem_rd_data >> (lane_w * lane_sel);

    // mask to size, then sign or zero extend
    always_comb begin
        case (wb.funct3)
            f3_b: begin
                load_value = {{(xlen-lane_w){lane_data[lane_w-1]}}, lane_data[lane_w-1:0]};
            end
            f3_h: begin
                load_value = {{(xlen-2*lane_w){lane_data[2*lane_w-1]}},
                              lane_data[2*lane_w-1:0]};
            end
            f3_bu: begin
                load_value = {{(xlen-lane_w){1'b0}}, lane_data[lane_w-1:0]};
            end
            f3_hu: begin
                load_value = {{(xlen-2*lane_w){1'b0}}, lane_data[2*lane_w-1:0]};
            end
            default: begin
                // lw and undefined sizes take the whole word
                load_value = lane_data;
            end
        endcase
    end

    // pick the write source
    always_comb begin
        case (wb.wb_sel)
            wb_pc4:  wr_value = wb.pc4;
            wb_mem:  wr_value = load_value;
            default: wr_value = wb.alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_wr_en   <= 1'b0;
            reg_wr_rd   <= '0;
            reg_wr_data <= '0;
        end else begin
            // a one-cycle write pulse only for valid writers
            reg_wr_en   <= wb.valid && wb.reg_wr_en;
            reg_wr_rd   <= wb.rd;
            reg_wr_data <= wr_value;
        end
    end

endmodule

/* source/lsu_pipeline_top.sv */
`timescale 1ns/1ps

module lsu_pipeline_top #(
    // ram depth in words, power of two
    parameter int mem_words = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        reg_wr_en,
    output logic [4:0]  reg_wr_rd,
    output logic [31:0] reg_wr_data
);

    // stage-to-stage buses
    exmem_if ex_bus ();
    memwb_if wb_bus ();

    // execute registers at the edge that samples in_valid
    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex       (ex_bus.src)
    );

    // ram access and payload register one edge later
    memory_stage #(
        .mem_words (mem_words)
    ) u_memory (
        .clk   (clk),
        .reset (reset),
        .ex    (ex_bus.dst),
        .wb    (wb_bus.src)
    );

    // write port registered on the third edge
    writeback_stage u_writeback (
        .clk         (clk),
        .reset       (reset),
        .wb          (wb_bus.dst),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_rd   (reg_wr_rd),
        .reg_wr_data (reg_wr_data)
    );

endmodule

/* tb/tb_lsu_pipeline.sv */
`timescale 1ns/1ps

module tb_lsu_pipeline;

    // register stages from the input to the write port
    // the sampling edge is the first of them
    localparam int latency = 3;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        reg_wr_en;
    logic [4:0]  reg_wr_rd;
    logic [31:0] reg_wr_data;

    // vectors as read from the data file
    logic [31:0] instr_v[$];
    logic [31:0] pc_v[$];
    logic [31:0] rs1_v[$];
    logic [31:0] rs2_v[$];
    logic        exp_en_v[$];
    logic [4:0]  exp_rd_v[$];
    logic [31:0] exp_data_v[$];

    // vectors in flight with the edge count at which each result is due
    int pend_idx_q[$];
    int pend_edge_q[$];

    int edge_cnt = 0;
    int num_vec = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int checked_cnt = 0;
    bit loaded = 1'b0;
    bit checking = 1'b0;

    lsu_pipeline_top DUT (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_rd   (reg_wr_rd),
        .reg_wr_data (reg_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // comment and blank lines scan fewer than seven fields and are skipped
    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [31:0] f [7];
        fd = $fopen("tb/lsu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the data file tb/lsu_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n == 7) begin
                instr_v.push_back(f[0]);
                pc_v.push_back(f[1]);
                rs1_v.push_back(f[2]);
                rs2_v.push_back(f[3]);
                exp_en_v.push_back(f[4][0]);
                exp_rd_v.push_back(f[5][4:0]);
                exp_data_v.push_back(f[6]);
            end
        end
        $fclose(fd);
    endtask

    // drive one vector just after an edge so that the next edge samples it
    task automatic issue_vector(input int idx);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        instr    = instr_v[idx];
        pc       = pc_v[idx];
        rs1_data = rs1_v[idx];
        rs2_data = rs2_v[idx];
        pend_idx_q.push_back(idx);
        pend_edge_q.push_back(edge_cnt + latency);
    endtask

    task automatic check_result(input int idx);
        bit ok;
        ok = 1'b1;
        if (!exp_en_v[idx]) begin
            if (reg_wr_en !== 1'b0) begin
                $display("CHECK FAILED at %0t: vector %0d wrote x%0d, no write expected",
                         $time, idx, reg_wr_rd);
                ok = 1'b0;
            end
        end else if (reg_wr_en !== 1'b1) begin
            $display("CHECK FAILED at %0t: vector %0d gave no write", $time, idx);
            ok = 1'b0;
        end else if (reg_wr_rd !== exp_rd_v[idx]) begin
            $display("CHECK FAILED at %0t: vector %0d rd x%0d, expected x%0d",
                     $time, idx, reg_wr_rd, exp_rd_v[idx]);
            ok = 1'b0;
        end else if (reg_wr_data !== exp_data_v[idx]) begin
            $display("CHECK FAILED at %0t: vector %0d data %h, expected %h",
                     $time, idx, reg_wr_data, exp_data_v[idx]);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
            $display("vector %0d: pass", idx);
        end else begin
            fail_cnt++;
            $display("vector %0d: fail", idx);
        end
        checked_cnt++;
    endtask

    // sample the write port mid-cycle once per slot
    always @(negedge clk) begin
        if (checking) begin
            if (pend_edge_q.size() > 0 && pend_edge_q[0] == edge_cnt) begin
                check_result(pend_idx_q[0]);
                pend_idx_q.delete(0);
                pend_edge_q.delete(0);
            end else if (reg_wr_en !== 1'b0) begin
                $display("CHECK FAILED at %0t: write port active in an empty slot", $time);
                fail_cnt++;
            end
        end
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        load_vectors();
        num_vec = instr_v.size();
        if (num_vec == 0) begin
            $display("no test vectors were read, the data file is missing or empty");
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            #1;
            reset    = 1'b0;
            checking = 1'b1;
            for (int i = 0; i < num_vec; i++) begin
                issue_vector(i);
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            // addi x1 left on the bus, only in_valid may start a write
            instr    = 32'h0010_0093;
            wait (checked_cnt == num_vec);
            // a few idle slots after the stream
            repeat (2) @(negedge clk);
            #1;
            $display("vectors checked %0d, passed %0d, failed %0d",
                     checked_cnt, pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt == num_vec) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // watchdog scaled by the vector count
    initial begin
        wait (loaded);
        #((num_vec + 20) * 10);
        $display("timeout: the run did not finish within %0d ns", (num_vec + 20) * 10);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* flist.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/exmem_if.sv
source/memwb_if.sv
source/data_memory.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/lsu_pipeline_top.sv
tb/tb_lsu_pipeline.sv

/* Makefile */
# Verilator build and run of the lsu pipeline testbench

BIN := obj_dir/Vtb_lsu_pipeline
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): flist.f $(SRCS)
	verilator --binary --timescale 1ns/1ps --top-module tb_lsu_pipeline \
		-Mdir obj_dir -f flist.f

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/lsu_testdata.txt */
// columns, all hex: instr pc rs1_data rs2_data exp_wr_en exp_rd exp_data
// rd and data are don't care where exp_wr_en is 0
0020A023 00000000 00000100 11223344 0 00 00000000
0000A283 00000004 00000100 00000000 1 05 11223344
0020A223 00000008 00000100 A5A50F0F 0 00 00000000
0040A303 0000000C 00000100 00000000 1 06 A5A50F0F
0000A283 00000010 00000100 00000000 1 05 11223344
0020A023 00000014 00000110 00000000 0 00 00000000
00208023 00000018 00000110 000000AA 0 00 00000000
00208023 0000001C 00000111 123456BB 0 00 00000000
00208023 00000020 00000112 000000CC 0 00 00000000
00208023 00000024 00000113 000000DD 0 00 00000000
0000A283 00000028 00000110 00000000 1 05 DDCCBBAA
0020A023 0000002C 00000114 FFFFFFFF 0 00 00000000
00209023 00000030 00000114 ABCD1234 0 00 00000000
00209023 00000034 00000116 00005678 0 00 00000000
0040A303 00000038 00000110 00000000 1 06 56781234
0020A023 0000003C 00000120 9C7EA512 0 00 00000000
00008403 00000040 00000121 00000000 1 08 FFFFFFA5
0000C503 00000044 00000121 00000000 1 0A 000000A5
00008403 00000048 00000123 00000000 1 08 FFFFFF9C
0000C503 0000004C 00000123 00000000 1 0A 0000009C
00009483 00000050 00000122 00000000 1 09 FFFF9C7E
0000D583 00000054 00000122 00000000 1 0B 00009C7E
0080A383 00000058 00000118 00000000 1 07 9C7EA512
FF008613 0000005C 00001000 00000000 1 0C 00000FF0
008000EF 00000060 12345678 9ABCDEF0 1 01 00000064
00508013 00000064 00000010 00000000 0 00 00000000
0000A003 00000068 00000100 00000000 0 00 00000000
0020A423 0000006C 00000128 0BADF00D 0 00 00000000
FF008613 00000070 00000020 00000000 1 0C 00000010
0080A383 00000074 00000128 00000000 1 07 0BADF00D
008000EF 00000078 00000000 00000000 1 01 0000007C
0000D583 0000007C 00000132 00000000 1 0B 00000BAD
00008403 00000080 00000130 00000000 1 08 0000000D
00208023 00000084 00000131 00000077 0 00 00000000
0000A283 00000088 00000130 00000000 1 05 0BAD770D
002081B3 0000008C 00000005 00000007 0 00 00000000
